// ==== meta_buffer.f ====
rtl/meta_pkg.sv
rtl/meta_store_if.sv
rtl/meta_fifo.sv
rtl/atop_slot_table.sv
rtl/meta_buffer_top.sv
tb/meta_buffer_checker.sv
tb/meta_buffer_tb.sv

// ==== tb/meta_buffer_tb.sv ====
// --------------------------------------------------
// Meta buffer testbench
// Table driven requests, a response model with B and
// two-beat R, and a scoreboard for restored meta
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module meta_buffer_tb;

  localparam int TIMEOUT  = 64;
  localparam int NUM_ROWS = 15;

  typedef struct packed {
    logic [3:0]         test;
    logic               wr;
    meta_pkg::atop_e    atop;
    meta_pkg::in_id_t   id;
    meta_pkg::node_id_t src;
    logic               hold;
    logic [3:0]         stall;
  } row_t;

  // One accepted request still waiting for its responses
  typedef struct packed {
    logic                wr;
    meta_pkg::atop_e     atop;
    meta_pkg::slot_idx_t slot;
    meta_pkg::meta_t     meta;
    logic                b_done;
  } pend_t;

  // Test, write, atomic kind, ID, source, hold response, AW stall cycles
  localparam row_t TABLE [NUM_ROWS] = '{
    '{4'd1, 1'b1, meta_pkg::ATOP_NONE,  4'h5, 4'h1, 1'b1, 4'd0},
    '{4'd1, 1'b1, meta_pkg::ATOP_NONE,  4'ha, 4'h2, 1'b1, 4'd0},
    '{4'd1, 1'b1, meta_pkg::ATOP_NONE,  4'h7, 4'h3, 1'b0, 4'd0},
    '{4'd2, 1'b0, meta_pkg::ATOP_NONE,  4'h3, 4'h4, 1'b0, 4'd0},
    '{4'd2, 1'b0, meta_pkg::ATOP_NONE,  4'h9, 4'h5, 1'b1, 4'd0},
    '{4'd2, 1'b0, meta_pkg::ATOP_NONE,  4'hc, 4'h6, 1'b1, 4'd0},
    '{4'd3, 1'b1, meta_pkg::ATOP_STORE, 4'h2, 4'h7, 1'b1, 4'd0},
    '{4'd3, 1'b1, meta_pkg::ATOP_STORE, 4'he, 4'h8, 1'b1, 4'd0},
    '{4'd4, 1'b1, meta_pkg::ATOP_LOAD,  4'h6, 4'h9, 1'b1, 4'd0},
    '{4'd4, 1'b1, meta_pkg::ATOP_STORE, 4'h1, 4'ha, 1'b1, 4'd0},
    '{4'd4, 1'b1, meta_pkg::ATOP_STORE, 4'h8, 4'hb, 1'b1, 4'd0},
    '{4'd5, 1'b1, meta_pkg::ATOP_NONE,  4'h0, 4'hc, 1'b1, 4'd0},
    '{4'd5, 1'b1, meta_pkg::ATOP_NONE,  4'h1, 4'hd, 1'b1, 4'd0},
    '{4'd5, 1'b1, meta_pkg::ATOP_NONE,  4'h2, 4'he, 1'b1, 4'd0},
    '{4'd5, 1'b1, meta_pkg::ATOP_NONE,  4'h3, 4'hf, 1'b1, 4'd0}
  };

  // Fifth write of test 5 and the stalled atomic of test 6
  localparam int NUM_EXTRA = 3;
  localparam row_t EXTRA [NUM_EXTRA] = '{
    '{4'd5, 1'b1, meta_pkg::ATOP_NONE,  4'h4, 4'h0, 1'b1, 4'd0},
    '{4'd6, 1'b1, meta_pkg::ATOP_STORE, 4'hd, 4'h1, 1'b1, 4'd0},
    '{4'd6, 1'b1, meta_pkg::ATOP_LOAD,  4'hb, 4'h2, 1'b1, 4'd4}
  };

  logic               clk_i;
  logic               arst_n_i;
  logic               aw_valid_i;
  meta_pkg::in_id_t   aw_id_i;
  meta_pkg::atop_e    aw_atop_i;
  meta_pkg::node_id_t aw_src_i;
  logic               aw_ready_i;
  logic               aw_ready_o;
  logic               aw_valid_o;
  meta_pkg::out_id_t  aw_id_o;
  logic               ar_valid_i;
  meta_pkg::in_id_t   ar_id_i;
  meta_pkg::node_id_t ar_src_i;
  logic               ar_ready_i;
  logic               ar_ready_o;
  logic               ar_valid_o;
  meta_pkg::out_id_t  ar_id_o;
  logic               b_valid_i;
  meta_pkg::out_id_t  b_id_i;
  logic               b_ready_i;
  logic               b_ready_o;
  logic               b_valid_o;
  meta_pkg::in_id_t   b_id_o;
  meta_pkg::node_id_t b_src_o;
  logic               r_valid_i;
  meta_pkg::out_id_t  r_id_i;
  logic               r_last_i;
  logic               r_ready_i;
  logic               r_ready_o;
  logic               r_valid_o;
  meta_pkg::in_id_t   r_id_o;
  logic               r_last_o;
  meta_pkg::node_id_t r_src_o;

  pend_t                           held [$];
  meta_pkg::meta_t                 wr_fifo_q [$];
  meta_pkg::meta_t                 rd_fifo_q [$];
  logic [meta_pkg::ATOP_SLOTS-1:0] b_pend;
  logic [meta_pkg::ATOP_SLOTS-1:0] r_pend;
  logic [31:0]                     lfsr_q;
  int                              err_cnt;
  int                              check_cnt;
  int                              test_cnt;
  int                              test_fail_cnt;

  meta_buffer_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    #1_000_000;
    $display("Simulation did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  task automatic random_bit(output logic b);
    lfsr_q = lfsr_step(lfsr_q);
    b      = lfsr_q[0];
  endtask

  function automatic meta_pkg::slot_idx_t lowest_free();
    meta_pkg::slot_idx_t idx;
    logic                found;
    idx   = '0;
    found = 1'b0;
    for (int i = 0; i < meta_pkg::ATOP_SLOTS; i++) begin
      if (!found && !b_pend[i] && !r_pend[i]) begin
        idx   = meta_pkg::slot_idx_t'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  function automatic logic has_room(input row_t r);
    if (!r.wr) return rd_fifo_q.size() < meta_pkg::FIFO_DEPTH;
    if (r.atop == meta_pkg::ATOP_NONE) return wr_fifo_q.size() < meta_pkg::FIFO_DEPTH;
    return (b_pend | r_pend) != '1;
  endfunction

  function automatic logic out_valid(input logic wr);
    return wr ? aw_valid_o : ar_valid_o;
  endfunction

  function automatic logic in_ready(input logic wr);
    return wr ? aw_ready_o : ar_ready_o;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1:       return "non-atomic writes";
      2:       return "non-atomic reads";
      3:       return "atomic stores";
      4:       return "atomic load slot hold";
      5:       return "full AW FIFO";
      6:       return "stalled atomic ID";
      default: return "unknown";
    endcase
  endfunction

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic check_in_id(input string name, input meta_pkg::in_id_t got,
                             input meta_pkg::in_id_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_out_id(input string name, input meta_pkg::out_id_t got,
                              input meta_pkg::out_id_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_node(input string name, input meta_pkg::node_id_t got,
                            input meta_pkg::node_id_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic send_b(input pend_t e);
    meta_pkg::meta_t exp;
    logic            atop;
    logic            hs;
    logic            rdy;
    int              cnt;
    atop = (e.atop != meta_pkg::ATOP_NONE);
    // Non-atomic writes come back in request order
    if (atop) exp = e.meta;
    else exp = wr_fifo_q[0];
    b_valid_i = 1'b1;
    b_id_i    = atop ? meta_pkg::out_id_t'(e.slot) : meta_pkg::NON_ATOP_ID;
    hs        = 1'b0;
    cnt       = 0;
    while (!hs && cnt < TIMEOUT) begin
      random_bit(rdy);
      b_ready_i = rdy;
      @(negedge clk_i);
      if (!b_valid_o || (b_ready_o !== b_ready_i)) begin
        flag_error("B valid or ready not passed through");
      end
      // Meta stays on the head until the consumer takes the response
      check_in_id("b_id_o", b_id_o, exp.id);
      check_node("b_src_o", b_src_o, exp.src);
      hs = b_ready_i;
      @(posedge clk_i);
      #2;
      cnt++;
    end
    if (!hs) flag_error("B response not accepted before the timeout");
    b_valid_i = 1'b0;
    if (atop) b_pend[e.slot] = 1'b0;
    else void'(wr_fifo_q.pop_front());
  endtask

  task automatic send_r(input pend_t e);
    meta_pkg::meta_t exp;
    logic            atop;
    logic            hs;
    logic            rdy;
    int              cnt;
    atop = (e.atop != meta_pkg::ATOP_NONE);
    if (atop) exp = e.meta;
    else exp = rd_fifo_q[0];
    r_id_i = atop ? meta_pkg::out_id_t'(e.slot) : meta_pkg::NON_ATOP_ID;
    for (int beat = 0; beat < 2; beat++) begin
      r_valid_i = 1'b1;
      r_last_i  = (beat == 1);
      hs        = 1'b0;
      cnt       = 0;
      while (!hs && cnt < TIMEOUT) begin
        random_bit(rdy);
        r_ready_i = rdy;
        @(negedge clk_i);
        if (!r_valid_o || (r_last_o !== r_last_i) || (r_ready_o !== r_ready_i)) begin
          flag_error("R valid, ready or last not passed through");
        end
        // Same restored meta on every beat of the burst
        check_in_id("r_id_o", r_id_o, exp.id);
        check_node("r_src_o", r_src_o, exp.src);
        hs = r_ready_i;
        @(posedge clk_i);
        #2;
        cnt++;
      end
      if (!hs) flag_error("R beat not accepted before the timeout");
    end
    r_valid_i = 1'b0;
    r_last_i  = 1'b0;
    if (atop) r_pend[e.slot] = 1'b0;
    else void'(rd_fifo_q.pop_front());
  endtask

  // Returns the next response owed to one outstanding request
  task automatic respond(input int idx);
    pend_t e;
    e = held[idx];
    if (e.wr && !e.b_done) begin
      send_b(e);
      if (e.atop == meta_pkg::ATOP_LOAD) begin
        held[idx].b_done = 1'b1;
      end else begin
        held.delete(idx);
      end
    end else begin
      send_r(e);
      held.delete(idx);
    end
  endtask

  task automatic send_req(input row_t r);
    pend_t             e;
    meta_pkg::out_id_t exp_id;
    logic              hs;
    int                cnt;
    e.wr     = r.wr;
    e.atop   = r.atop;
    e.meta   = '{id: r.id, src: r.src};
    e.b_done = 1'b0;
    e.slot   = '0;
    if (r.wr) begin
      aw_valid_i = 1'b1;
      aw_id_i    = r.id;
      aw_atop_i  = r.atop;
      aw_src_i   = r.src;
      aw_ready_i = (r.stall == 0);
    end else begin
      ar_valid_i = 1'b1;
      ar_id_i    = r.id;
      ar_src_i   = r.src;
    end
    // No room, so the request is held off until the oldest one drains
    cnt = 0;
    while (!has_room(r) && cnt < TIMEOUT) begin
      @(negedge clk_i);
      if (out_valid(r.wr) || in_ready(r.wr)) flag_error("request offered without room");
      @(posedge clk_i);
      #2;
      if (held.size() > 0) respond(0);
      cnt++;
    end
    if (r.atop != meta_pkg::ATOP_NONE) e.slot = lowest_free();
    exp_id = (r.atop != meta_pkg::ATOP_NONE) ? meta_pkg::out_id_t'(e.slot) :
             meta_pkg::NON_ATOP_ID;
    // Slot chosen in the first valid cycle, even if another frees meanwhile
    for (int s = 0; s < r.stall; s++) begin
      @(negedge clk_i);
      if (!aw_valid_o) flag_error("aw_valid_o dropped during a stall");
      check_out_id("aw_id_o", aw_id_o, exp_id);
      @(posedge clk_i);
      #2;
      if (s == 0 && held.size() > 0) respond(0);
    end
    aw_ready_i = 1'b1;
    hs         = 1'b0;
    cnt        = 0;
    while (!hs && cnt < TIMEOUT) begin
      @(negedge clk_i);
      hs = out_valid(r.wr) && in_ready(r.wr);
      if (hs) check_out_id(r.wr ? "aw_id_o" : "ar_id_o", r.wr ? aw_id_o : ar_id_o, exp_id);
      @(posedge clk_i);
      #2;
      cnt++;
    end
    aw_valid_i = 1'b0;
    ar_valid_i = 1'b0;
    if (!hs) begin
      flag_error("request not accepted before the timeout");
    end else begin
      if (!r.wr) begin
        rd_fifo_q.push_back(e.meta);
      end else if (r.atop == meta_pkg::ATOP_NONE) begin
        wr_fifo_q.push_back(e.meta);
      end else begin
        b_pend[e.slot] = 1'b1;
        r_pend[e.slot] = (r.atop == meta_pkg::ATOP_LOAD);
      end
      held.push_back(e);
      cnt = held.size();
      while (!r.hold && held.size() == cnt) respond(cnt - 1);
    end
  endtask

  // Remaining responses go back newest first
  task automatic finish_test(input int t, input int errs);
    while (held.size() > 0) respond(held.size() - 1);
    test_cnt++;
    if (errs != 0) test_fail_cnt++;
    $display("test %0d %-24s %s", t, test_name(t), (errs == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    int   start_err;
    row_t r;
    row_t nxt;
    arst_n_i      = 1'b0;
    aw_valid_i    = 1'b0;
    aw_id_i       = '0;
    aw_atop_i     = meta_pkg::ATOP_NONE;
    aw_src_i      = '0;
    aw_ready_i    = 1'b0;
    ar_valid_i    = 1'b0;
    ar_id_i       = '0;
    ar_src_i      = '0;
    ar_ready_i    = 1'b0;
    b_valid_i     = 1'b0;
    b_id_i        = '0;
    b_ready_i     = 1'b0;
    r_valid_i     = 1'b0;
    r_id_i        = '0;
    r_last_i      = 1'b0;
    r_ready_i     = 1'b0;
    b_pend        = '0;
    r_pend        = '0;
    lfsr_q        = 32'h2e21_b63e;
    err_cnt       = 0;
    check_cnt     = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    start_err     = 0;
    repeat (16) @(posedge clk_i);
    #2;
    arst_n_i   = 1'b1;
    aw_ready_i = 1'b1;
    ar_ready_i = 1'b1;
    b_ready_i  = 1'b1;
    for (int i = 0; i < NUM_ROWS + NUM_EXTRA; i++) begin
      r = (i < NUM_ROWS) ? TABLE[i] : EXTRA[i - NUM_ROWS];
      send_req(r);
      if (i < NUM_ROWS + NUM_EXTRA - 1) begin
        nxt = (i + 1 < NUM_ROWS) ? TABLE[i + 1] : EXTRA[i + 1 - NUM_ROWS];
      end else begin
        nxt = '0;
      end
      if (nxt.test != r.test) begin
        finish_test(r.test, err_cnt - start_err);
        start_err = err_cnt;
      end
    end
    err_cnt += UUT.u_checker.fail_cnt;
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             test_cnt, test_fail_cnt, check_cnt, err_cnt, UUT.u_checker.fail_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/meta_buffer_checker.sv ====
// ------------------------------------------------
// Meta buffer checker
// AW stability under stall, B valid pass-through
// and unique IDs for outstanding atomics
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module meta_buffer_checker (
  input logic                            clk_i,
  input logic                            arst_n_i,
  input logic                            out_aw_valid_i,
  input logic                            out_aw_ready_i,
  input meta_pkg::out_id_t               out_aw_id_i,
  input meta_pkg::atop_e                 aw_atop_i,
  input logic                            in_b_valid_i,
  input logic                            out_b_valid_i,
  input logic [meta_pkg::ATOP_SLOTS-1:0] slot_busy_i
);

  int unsigned fail_cnt = 0;

  // Outgoing AW holds its ID until downstream takes it
  aw_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_aw_valid_i && !out_aw_ready_i |=> out_aw_valid_i && $stable(out_aw_id_i))
    else begin
      $error("AW valid or ID changed during a stall");
      fail_cnt++;
    end

  b_valid_pass: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_b_valid_i == in_b_valid_i)
    else begin
      $error("b_valid_o differs from b_valid_i");
      fail_cnt++;
    end

  // An atomic may only take a slot nobody else holds
  atop_unique: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_aw_valid_i && out_aw_ready_i && (aw_atop_i != meta_pkg::ATOP_NONE)
    |-> !slot_busy_i[meta_pkg::slot_idx_t'(out_aw_id_i)])
    else begin
      $error("atomic AW reuses an outstanding ID");
      fail_cnt++;
    end

endmodule

bind meta_buffer_top meta_buffer_checker u_checker (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .out_aw_valid_i (aw_valid_o),
  .out_aw_ready_i (aw_ready_i),
  .out_aw_id_i    (aw_id_o),
  .aw_atop_i      (aw_atop_i),
  .in_b_valid_i   (b_valid_i),
  .out_b_valid_i  (b_valid_o),
  .slot_busy_i    (u_slots.b_pend_q | u_slots.r_pend_q)
);

`default_nettype wire

// ==== rtl/meta_buffer_top.sv ====
// ------------------------------------------------
// Meta buffer top level
// Remaps AXI IDs on AW/AR, stores original ID and
// source node, restores them on B/R responses
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module meta_buffer_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // AW
  input  logic               aw_valid_i,
  input  meta_pkg::in_id_t   aw_id_i,
  input  meta_pkg::atop_e    aw_atop_i,
  input  meta_pkg::node_id_t aw_src_i,
  input  logic               aw_ready_i,
  output logic               aw_ready_o,
  output logic               aw_valid_o,
  output meta_pkg::out_id_t  aw_id_o,
  // AR
  input  logic               ar_valid_i,
  input  meta_pkg::in_id_t   ar_id_i,
  input  meta_pkg::node_id_t ar_src_i,
  input  logic               ar_ready_i,
  output logic               ar_ready_o,
  output logic               ar_valid_o,
  output meta_pkg::out_id_t  ar_id_o,
  // B
  input  logic               b_valid_i,
  input  meta_pkg::out_id_t  b_id_i,
  input  logic               b_ready_i,
  output logic               b_ready_o,
  output logic               b_valid_o,
  output meta_pkg::in_id_t   b_id_o,
  output meta_pkg::node_id_t b_src_o,
  // R
  input  logic               r_valid_i,
  input  meta_pkg::out_id_t  r_id_i,
  input  logic               r_last_i,
  input  logic               r_ready_i,
  output logic               r_ready_o,
  output logic               r_valid_o,
  output meta_pkg::in_id_t   r_id_o,
  output logic               r_last_o,
  output meta_pkg::node_id_t r_src_o
);

  meta_store_if aw_store ();
  meta_store_if ar_store ();

  logic                aw_is_atop;
  logic                aw_room;
  logic                aw_hs;
  logic                ar_room;
  logic                slot_ok;
  meta_pkg::slot_idx_t slot_idx;
  logic                b_is_atop;
  logic                r_is_atop;
  logic                b_hs;
  logic                r_last_hs;
  meta_pkg::meta_t     aw_meta;
  meta_pkg::meta_t     slot_b_meta;
  meta_pkg::meta_t     slot_r_meta;
  meta_pkg::meta_t     b_meta;
  meta_pkg::meta_t     r_meta;

  // Request side
  assign aw_is_atop = (aw_atop_i != meta_pkg::ATOP_NONE);
  assign aw_room    = aw_is_atop ? slot_ok : !aw_store.full;
  assign aw_valid_o = aw_valid_i && aw_room;
  assign aw_ready_o = aw_ready_i && aw_room;
  assign aw_hs      = aw_valid_o && aw_ready_i;
  assign aw_id_o    = aw_is_atop ? meta_pkg::out_id_t'(slot_idx) : meta_pkg::NON_ATOP_ID;
  assign aw_meta    = '{id: aw_id_i, src: aw_src_i};

  assign aw_store.push      = aw_hs && !aw_is_atop;
  assign aw_store.push_meta = aw_meta;

  assign ar_room    = !ar_store.full;
  assign ar_valid_o = ar_valid_i && ar_room;
  assign ar_ready_o = ar_ready_i && ar_room;
  assign ar_id_o    = meta_pkg::NON_ATOP_ID;

  assign ar_store.push      = ar_valid_o && ar_ready_i;
  assign ar_store.push_meta = '{id: ar_id_i, src: ar_src_i};

  // Response side, IDs below the slot count belong to atomics
  assign b_is_atop = (b_id_i < meta_pkg::out_id_t'(meta_pkg::ATOP_SLOTS));
  assign r_is_atop = (r_id_i < meta_pkg::out_id_t'(meta_pkg::ATOP_SLOTS));
  assign b_hs      = b_valid_i && b_ready_i;
  assign r_last_hs = r_valid_i && r_ready_i && r_last_i;

  assign b_meta = b_is_atop ? slot_b_meta : aw_store.pop_meta;
  assign r_meta = r_is_atop ? slot_r_meta : ar_store.pop_meta;

  assign b_valid_o = b_valid_i;
  assign b_ready_o = b_ready_i;
  assign b_id_o    = b_meta.id;
  assign b_src_o   = b_meta.src;

  assign r_valid_o = r_valid_i;
  assign r_ready_o = r_ready_i;
  assign r_last_o  = r_last_i;
  assign r_id_o    = r_meta.id;
  assign r_src_o   = r_meta.src;

  // Read meta leaves only after the last beat
  assign aw_store.pop = b_hs && !b_is_atop && !aw_store.empty;
  assign ar_store.pop = r_last_hs && !r_is_atop && !ar_store.empty;

  meta_fifo u_aw_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .store    (aw_store.store)
  );

  meta_fifo u_ar_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .store    (ar_store.store)
  );

  atop_slot_table u_slots (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .alloc_req_i  (aw_valid_o && aw_is_atop),
    .alloc_fire_i (aw_hs && aw_is_atop),
    .alloc_load_i (aw_atop_i == meta_pkg::ATOP_LOAD),
    .alloc_meta_i (aw_meta),
    .b_rel_i      (b_hs && b_is_atop),
    .b_slot_i     (meta_pkg::slot_idx_t'(b_id_i)),
    .r_rel_i      (r_last_hs && r_is_atop),
    .r_slot_i     (meta_pkg::slot_idx_t'(r_id_i)),
    .alloc_ok_o   (slot_ok),
    .alloc_slot_o (slot_idx),
    .b_meta_o     (slot_b_meta),
    .r_meta_o     (slot_r_meta)
  );

endmodule

`default_nettype wire

// ==== rtl/atop_slot_table.sv ====
// ------------------------------------------------
// Atomic slot table
// Hands out the lowest free slot as unique ID and
// keeps meta until both B and R parts are released
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module atop_slot_table (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  alloc_req_i,
  input  logic                  alloc_fire_i,
  input  logic                  alloc_load_i,
  input  meta_pkg::meta_t       alloc_meta_i,
  input  logic                  b_rel_i,
  input  meta_pkg::slot_idx_t   b_slot_i,
  input  logic                  r_rel_i,
  input  meta_pkg::slot_idx_t   r_slot_i,
  output logic                  alloc_ok_o,
  output meta_pkg::slot_idx_t   alloc_slot_o,
  output meta_pkg::meta_t       b_meta_o,
  output meta_pkg::meta_t       r_meta_o
);

  meta_pkg::meta_t               meta_q [meta_pkg::ATOP_SLOTS];
  logic [meta_pkg::ATOP_SLOTS-1:0] b_pend_q;
  logic [meta_pkg::ATOP_SLOTS-1:0] r_pend_q;
  logic [meta_pkg::ATOP_SLOTS-1:0] free;
  meta_pkg::slot_idx_t           lowest_free;
  logic                          hold_q;
  meta_pkg::slot_idx_t           hold_slot_q;

  // Slot is free only once neither response is outstanding
  assign free = ~(b_pend_q | r_pend_q);

  always_comb begin
    lowest_free = '0;
    for (int i = meta_pkg::ATOP_SLOTS - 1; i >= 0; i--) begin
      if (free[i]) begin
        lowest_free = meta_pkg::slot_idx_t'(i);
      end
    end
  end

  // A request waiting for ready keeps the slot it saw first
  assign alloc_slot_o = hold_q ? hold_slot_q : lowest_free;
  assign alloc_ok_o   = hold_q || (|free);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= alloc_req_i && !alloc_fire_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_req_i && !hold_q) begin
      hold_slot_q <= lowest_free;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_pend_q <= '0;
      r_pend_q <= '0;
    end else begin
      if (b_rel_i) begin
        b_pend_q[b_slot_i] <= 1'b0;
      end
      if (r_rel_i) begin
        r_pend_q[r_slot_i] <= 1'b0;
      end
      if (alloc_fire_i) begin
        b_pend_q[alloc_slot_o] <= 1'b1;
        // Stores never see an R beat
        r_pend_q[alloc_slot_o] <= alloc_load_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_fire_i) begin
      meta_q[alloc_slot_o] <= alloc_meta_i;
    end
  end

  assign b_meta_o = meta_q[b_slot_i];
  assign r_meta_o = meta_q[r_slot_i];

endmodule

`default_nettype wire

// ==== rtl/meta_fifo.sv ====
// ------------------------------------------------
// Meta FIFO
// In-order buffer of meta entries for non-atomic
// requests, head is registered (no fall-through)
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module meta_fifo (
  input logic         clk_i,
  input logic         arst_n_i,
  meta_store_if.store store
);

  meta_pkg::meta_t     mem [meta_pkg::FIFO_DEPTH];
  meta_pkg::fifo_ptr_t wr_ptr_q;
  meta_pkg::fifo_ptr_t rd_ptr_q;
  meta_pkg::fifo_cnt_t count_q;
  logic                do_push;
  logic                do_pop;

  assign store.full     = (count_q == meta_pkg::fifo_cnt_t'(meta_pkg::FIFO_DEPTH));
  assign store.empty    = (count_q == '0);
  assign store.pop_meta = mem[rd_ptr_q];

  assign do_pop  = store.pop && !store.empty;
  // A full FIFO still takes a push when the head leaves in the same clock
  assign do_push = store.push && (!store.full || do_pop);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == meta_pkg::fifo_ptr_t'(meta_pkg::FIFO_DEPTH - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == meta_pkg::fifo_ptr_t'(meta_pkg::FIFO_DEPTH - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= store.push_meta;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/meta_store_if.sv ====
// ------------------------------------------------
// Meta store interface
// Push and pop side of one in-order meta FIFO
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface meta_store_if;

  logic            push;
  meta_pkg::meta_t push_meta;
  logic            full;
  logic            pop;
  meta_pkg::meta_t pop_meta;
  logic            empty;

  // The FIFO itself
  modport store (
    input  push, push_meta, pop,
    output full, pop_meta, empty
  );

  // The block that fills and drains it
  modport user (
    output push, push_meta, pop,
    input  full, pop_meta, empty
  );

endinterface

`default_nettype wire

// ==== rtl/meta_pkg.sv ====
// ------------------------------------------------
// Meta buffer package
// Sizes, ID and node types, atomic kinds and the
// meta entry kept for every outstanding request
// ------------------------------------------------

`default_nettype none

package meta_pkg;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned ATOP_SLOTS = 2;
  localparam int unsigned IN_ID_W    = 4;
  localparam int unsigned OUT_ID_W   = 2;
  localparam int unsigned NODE_W     = 4;

  typedef logic [IN_ID_W-1:0]    in_id_t;
  typedef logic [OUT_ID_W-1:0]   out_id_t;
  typedef logic [NODE_W-1:0]     node_id_t;
  typedef logic [0:0]            slot_idx_t;
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;

  // Shared ID of all non-atomic requests, above every slot index
  localparam out_id_t NON_ATOP_ID = '1;

  typedef enum logic [1:0] {
    ATOP_NONE  = 2'd0,
    ATOP_STORE = 2'd1,
    ATOP_LOAD  = 2'd2
  } atop_e;

  typedef struct packed {
    in_id_t   id;
    node_id_t src;
  } meta_t;

endpackage

`default_nettype wire
